// File: common/shell_clk_pkg.sv
/*
 * Counter types and load constants shared by the reset and clock-enable blocks.
 * Referenced by scoped names from the RTL and the testbench.
 */
package shell_clk_pkg;

    //////////////////////////////
    // PLL watchdog
    //////////////////////////////

    // Down-counter for the PLL reset pulse
    typedef logic [7:0] pll_cnt_t;

    // 255 down to 0 gives a pulse of 256 clk_sys cycles
    localparam pll_cnt_t PLL_RST_LOAD = 8'd255;

    //////////////////////////////
    // Game reset stretch
    //////////////////////////////

    // Cycles of game reset kept after the last request
    typedef logic [7:0] rst_cnt_t;

    //////////////////////////////
    // Pixel clock enables
    //////////////////////////////

    // Divider from clk_sys down to the double pixel rate
    typedef logic [3:0] pxl_cnt_t;

endpackage

// File: common/shell_av_pkg.sv
/*
 * Audio sample definitions for the sound path between game and audio clock.
 */
package shell_av_pkg;

    //////////////////////////////
    // Audio samples
    //////////////////////////////

    // Bits per channel sample
    localparam int SAMPLE_W = 16;

    // Signed two's complement sample, one channel
    typedef logic signed [SAMPLE_W-1:0] sample_t;

endpackage

// File: reset/pll_watchdog.sv
/*
 * Restarts the external PLL when it drops lock. A falling lock bit loads a
 * counter and holds the PLL reset for a fixed pulse of 256 clk_sys cycles.
 */
`timescale 1ns/1ps

module pll_watchdog (
    input  logic clk_sys,
    input  logic RESET,
    input  logic pll_locked,
    output logic pll_rst
);

    // Lock bit from the previous cycle
    logic                   last_locked;
    shell_clk_pkg::pll_cnt_t rst_cnt;
    logic                   lock_lost;

    // High on the first cycle without lock
    assign lock_lost = last_locked & ~pll_locked;

    //////////////////////////////
    // Lock edge and pulse counter
    //////////////////////////////

    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            last_locked <= 1'b0;
            rst_cnt     <= '0;
            pll_rst     <= 1'b0;
        end else begin
            last_locked <= pll_locked;
            if (lock_lost) begin
                // A new loss restarts the pulse from the top
                pll_rst <= 1'b1;
                rst_cnt <= shell_clk_pkg::PLL_RST_LOAD;
            end else if (rst_cnt != '0) begin
                rst_cnt <= rst_cnt - 8'd1;
            end else begin
                // Count exhausted, let the PLL run
                pll_rst <= 1'b0;
            end
        end
    end

endmodule

// File: reset/reset_ctrl.sv
/*
 * Merges the button, status-word and lost-lock resets into one stretched game
 * reset, and releases a copy of it in step with the audio clock.
 */
`timescale 1ns/1ps

module reset_ctrl #(
    parameter shell_clk_pkg::rst_cnt_t RST_HOLD = 8'd16
) (
    input  logic clk_sys,
    input  logic RESET,
    input  logic clk_audio,
    input  logic pll_locked,
    input  logic rst_button,
    input  logic rst_status,
    output logic game_rst,
    output logic audio_rst
);

    logic                    rst_req;
    shell_clk_pkg::rst_cnt_t hold_cnt;

    // Two-flop release chain in the audio domain
    logic [1:0] audio_sync;

    // Any source keeps the game in reset
    assign rst_req = rst_button | rst_status | ~pll_locked;

    //////////////////////////////
    // Game reset stretch
    //////////////////////////////

    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            game_rst <= 1'b1;
            hold_cnt <= RST_HOLD;
        end else begin
            if (rst_req) begin
                // Reload while the request lasts
                game_rst <= 1'b1;
                hold_cnt <= RST_HOLD;
            end else if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - 8'd1;
            end else begin
                game_rst <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // Audio domain reset
    //////////////////////////////

    // Asserts at once with game_rst, releases on the second clk_audio edge
    always_ff @(posedge clk_audio or posedge game_rst) begin
        if (game_rst) begin
            audio_sync <= 2'b11;
        end else begin
            audio_sync <= {audio_sync[0], 1'b0};
        end
    end

    assign audio_rst = audio_sync[1];

endmodule

// File: video/pixel_strobes.sv
/*
 * Pixel clock enables derived from clk_sys: double rate, pixel rate, and a
 * centre strobe in the gap between pixel enables. Idle while game_rst is high.
 */
`timescale 1ns/1ps

module pixel_strobes #(
    parameter shell_clk_pkg::pxl_cnt_t PXL2_DIV = 4'd4
) (
    input  logic clk_sys,
    input  logic game_rst,
    output logic pxl2_cen,
    output logic pxl_cen,
    output logic pxl1_cen
);

    // Last count value before the divider wraps
    localparam shell_clk_pkg::pxl_cnt_t DIV_LAST = PXL2_DIV - 4'd1;

    shell_clk_pkg::pxl_cnt_t div_cnt;
    logic                    div_wrap;

    // Selects which pxl2_cen also carries pxl_cen
    logic half;

    assign div_wrap = (div_cnt == DIV_LAST);

    //////////////////////////////
    // Divider and halving toggle
    //////////////////////////////

    always_ff @(posedge clk_sys or posedge game_rst) begin
        if (game_rst) begin
            div_cnt  <= '0;
            half     <= 1'b0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
            pxl1_cen <= 1'b0;
        end else begin
            div_cnt  <= div_wrap ? '0 : div_cnt + 4'd1;
            pxl2_cen <= div_wrap;
            pxl_cen  <= div_wrap & half;
            if (div_wrap) begin
                half <= ~half;
            end
            // One cycle after a double-rate pulse without a pixel pulse
            pxl1_cen <= pxl2_cen & ~pxl_cen;
        end
    end

endmodule

// File: audio/audio_resync.sv
/*
 * Resamples game audio into the audio clock domain through two registers.
 * Mono builds feed the left channel to both outputs.
 */
`timescale 1ns/1ps

module audio_resync #(
    parameter bit STEREO = 1'b0
) (
    input  logic                  clk_audio,
    input  logic                  audio_rst,
    input  shell_av_pkg::sample_t snd_left,
    input  shell_av_pkg::sample_t snd_right,
    output shell_av_pkg::sample_t audio_l,
    output shell_av_pkg::sample_t audio_r
);

    // Right channel source before the first stage
    shell_av_pkg::sample_t right_src;

    // First capture stage, still close to clk_sys timing
    shell_av_pkg::sample_t left_sync;
    shell_av_pkg::sample_t right_sync;

    assign right_src = STEREO ? snd_right : snd_left;

    //////////////////////////////
    // Two-stage resample
    //////////////////////////////

    always_ff @(posedge clk_audio or posedge audio_rst) begin
        if (audio_rst) begin
            left_sync  <= '0;
            right_sync <= '0;
            audio_l    <= '0;
            audio_r    <= '0;
        end else begin
            left_sync  <= snd_left;
            right_sync <= right_src;
            audio_l    <= left_sync;
            audio_r    <= right_sync;
        end
    end

endmodule

// File: verilog/core_shell.sv
/*
 * Board-glue top level of the arcade shell: PLL watchdog, game reset,
 * pixel clock enables and the audio resample path, wired side by side.
 */
`timescale 1ns/1ps

module core_shell #(
    parameter shell_clk_pkg::rst_cnt_t RST_HOLD = 8'd16,
    parameter shell_clk_pkg::pxl_cnt_t PXL2_DIV = 4'd4,
    parameter bit                      STEREO   = 1'b0
) (
    input  logic                  clk_sys,
    input  logic                  RESET,
    input  logic                  clk_audio,

    // PLL lock watch
    input  logic                  pll_locked,
    output logic                  pll_rst,

    // Reset requests and game reset
    input  logic                  rst_button,
    input  logic                  rst_status,
    output logic                  game_rst,

    // Pixel clock enables
    output logic                  pxl2_cen,
    output logic                  pxl_cen,
    output logic                  pxl1_cen,

    // Sound
    input  shell_av_pkg::sample_t snd_left,
    input  shell_av_pkg::sample_t snd_right,
    output shell_av_pkg::sample_t audio_l,
    output shell_av_pkg::sample_t audio_r
);

    // Reset for the audio clock domain
    logic audio_rst;

    //////////////////////////////
    // Reset
    //////////////////////////////

    pll_watchdog pll_watchdog_i (
        .clk_sys    (clk_sys),
        .RESET      (RESET),
        .pll_locked (pll_locked),
        .pll_rst    (pll_rst)
    );

    reset_ctrl #(
        .RST_HOLD   (RST_HOLD)
    ) reset_ctrl_i (
        .clk_sys    (clk_sys),
        .RESET      (RESET),
        .clk_audio  (clk_audio),
        .pll_locked (pll_locked),
        .rst_button (rst_button),
        .rst_status (rst_status),
        .game_rst   (game_rst),
        .audio_rst  (audio_rst)
    );

    //////////////////////////////
    // Video
    //////////////////////////////

    pixel_strobes #(
        .PXL2_DIV   (PXL2_DIV)
    ) pixel_strobes_i (
        .clk_sys    (clk_sys),
        .game_rst   (game_rst),
        .pxl2_cen   (pxl2_cen),
        .pxl_cen    (pxl_cen),
        .pxl1_cen   (pxl1_cen)
    );

    //////////////////////////////
    // Audio
    //////////////////////////////

    audio_resync #(
        .STEREO     (STEREO)
    ) audio_resync_i (
        .clk_audio  (clk_audio),
        .audio_rst  (audio_rst),
        .snd_left   (snd_left),
        .snd_right  (snd_right),
        .audio_l    (audio_l),
        .audio_r    (audio_r)
    );

endmodule

// File: tb/core_shell_tb.sv
/*
 * Testbench for the shell glue. Walks the reset state, PLL watchdog, reset
 * requests, pixel strobes and the audio resample path of the top level.
 */
`timescale 1ns/1ps

module core_shell_tb;

    localparam shell_clk_pkg::rst_cnt_t RST_HOLD = 8'd16;
    localparam shell_clk_pkg::pxl_cnt_t PXL2_DIV = 4'd4;
    localparam int HOLD = int'(RST_HOLD);
    localparam int DIV  = int'(PXL2_DIV);
    // Load value counts down to zero, so one cycle more than the load
    localparam int PLL_PULSE = int'(shell_clk_pkg::PLL_RST_LOAD) + 1;

    logic clk_sys = 1'b0;
    logic clk_audio = 1'b0;
    logic RESET;
    logic pll_locked;
    logic pll_rst;
    logic rst_button;
    logic rst_status;
    logic game_rst;
    logic pxl2_cen;
    logic pxl_cen;
    logic pxl1_cen;
    shell_av_pkg::sample_t snd_left;
    shell_av_pkg::sample_t snd_right;
    shell_av_pkg::sample_t audio_l;
    shell_av_pkg::sample_t audio_r;

    int checks = 0;
    int errors = 0;
    int timeouts = 0;

    // Strobe monitor state
    int   gap = 0;
    logic seen2 = 1'b0;
    logic last_pxl = 1'b0;
    logic prev2_nopxl = 1'b0;
    int   n_pxl2 = 0;
    int   n_pxl = 0;
    int   n_pxl1 = 0;

    logic [31:0]           seed;
    shell_av_pkg::sample_t exp_left;
    shell_av_pkg::sample_t prev_left;
    shell_av_pkg::sample_t right_val;
    int                    cycles;
    int                    pll_hi;
    int                    pll_rises;
    int                    g_after;
    logic                  prev_pll;
    int                    c2;
    int                    cp;
    int                    c1;

    always #4 clk_sys = ~clk_sys;
    always #11 clk_audio = ~clk_audio;

    core_shell #(
        .RST_HOLD   (RST_HOLD),
        .PXL2_DIV   (PXL2_DIV),
        .STEREO     (1'b0)
    ) core_shell_i (
        .clk_sys    (clk_sys),
        .RESET      (RESET),
        .clk_audio  (clk_audio),
        .pll_locked (pll_locked),
        .pll_rst    (pll_rst),
        .rst_button (rst_button),
        .rst_status (rst_status),
        .game_rst   (game_rst),
        .pxl2_cen   (pxl2_cen),
        .pxl_cen    (pxl_cen),
        .pxl1_cen   (pxl1_cen),
        .snd_left   (snd_left),
        .snd_right  (snd_right),
        .audio_l    (audio_l),
        .audio_r    (audio_r)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            $display("error %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic check_reset_state(input string name);
        check_value({name, "_pll_rst"}, 32'd0, 32'(pll_rst));
        check_value({name, "_game_rst"}, 32'd1, 32'(game_rst));
        check_value({name, "_strobes"}, 32'd0, 32'({pxl2_cen, pxl_cen, pxl1_cen}));
        check_value({name, "_audio_l"}, 32'd0, 32'(audio_l));
        check_value({name, "_audio_r"}, 32'd0, 32'(audio_r));
    endtask

    // Called at a falling clk_sys edge, counts falling edges until the level
    task automatic wait_game_rst(input logic level, input int limit, input string name,
                                 output int n);
        n = 0;
        while (game_rst !== level && n < limit) begin
            @(negedge clk_sys);
            n++;
        end
        if (game_rst !== level) begin
            timeouts++;
            $display("%s: game_rst did not reach %0b within %0d cycles", name, level, limit);
        end
    endtask

    task automatic pulse_request(input string name, input bit use_status);
        int n;
        @(posedge clk_sys);
        if (use_status) begin
            rst_status <= 1'b1;
        end else begin
            rst_button <= 1'b1;
        end
        @(posedge clk_sys);
        rst_status <= 1'b0;
        rst_button <= 1'b0;
        @(negedge clk_sys);
        wait_game_rst(1'b1, 1, {name, "_rise"}, n);
        wait_game_rst(1'b0, HOLD + 2, {name, "_fall"}, n);
        checks++;
        assert (n >= HOLD) else begin
            errors++;
            $display("%s: game_rst released after %0d cycles, short of the %0d cycle hold",
                     name, n, HOLD);
        end
    endtask

    //////////////////////////////
    // Pixel strobe monitor
    //////////////////////////////

    always @(negedge clk_sys) begin
        if (game_rst === 1'b1) begin
            check_value("strobes_in_reset", 32'd0, 32'({pxl2_cen, pxl_cen, pxl1_cen}));
            gap         = 0;
            seen2       = 1'b0;
            prev2_nopxl = 1'b0;
        end else if (game_rst === 1'b0) begin
            gap++;
            // Centre strobe follows a double-rate pulse without pxl_cen
            check_value("pxl1_cen", 32'(prev2_nopxl), 32'(pxl1_cen));
            if (pxl_cen) begin
                check_value("pxl_cen_with_pxl2", 32'd1, 32'(pxl2_cen));
                n_pxl++;
            end
            if (pxl2_cen) begin
                if (seen2) begin
                    check_value("pxl2_spacing", 32'(DIV), 32'(gap));
                    check_value("pxl_cen_alternate", 32'(!last_pxl), 32'(pxl_cen));
                end
                seen2    = 1'b1;
                gap      = 0;
                last_pxl = pxl_cen;
                n_pxl2++;
            end
            if (pxl1_cen) begin
                n_pxl1++;
            end
            prev2_nopxl = pxl2_cen & ~pxl_cen;
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        RESET      <= 1'b1;
        pll_locked <= 1'b1;
        rst_button <= 1'b0;
        rst_status <= 1'b0;
        // Nonzero sound so the audio outputs show the reset
        snd_left   <= 16'h5a5a;
        snd_right  <= 16'h3c3c;
        seed = 32'd34;

        // Reset state
        repeat (2) begin
            @(posedge clk_sys);
            @(negedge clk_sys);
            check_reset_state("reset_hold");
        end
        @(posedge clk_sys);
        RESET <= 1'b0;
        @(negedge clk_sys);
        check_reset_state("reset_release");
        wait_game_rst(1'b0, HOLD + 2, "reset_release", cycles);

        // Strobe counts over whole periods
        repeat (3 * DIV) @(posedge clk_sys);
        c2 = n_pxl2;
        cp = n_pxl;
        c1 = n_pxl1;
        repeat (16 * DIV) @(posedge clk_sys);
        check_value("pxl2_count", 32'd16, 32'(n_pxl2 - c2));
        check_value("pxl_count", 32'd8, 32'(n_pxl - cp));
        check_value("pxl1_count", 32'd8, 32'(n_pxl1 - c1));

        // Lock drop for five cycles
        @(negedge clk_sys);
        check_value("pll_rst_idle", 32'd0, 32'(pll_rst));
        pll_hi    = 0;
        pll_rises = 0;
        g_after   = 0;
        prev_pll  = 1'b0;
        @(posedge clk_sys);
        pll_locked <= 1'b0;
        for (int i = 0; i < PLL_PULSE + 40; i++) begin
            @(posedge clk_sys);
            if (i == 4) begin
                pll_locked <= 1'b1;
            end
            @(negedge clk_sys);
            if (pll_rst && !prev_pll) begin
                pll_rises++;
            end
            if (pll_rst) begin
                pll_hi++;
            end
            prev_pll = pll_rst;
            if (i <= 4) begin
                check_value("lock_loss_game_rst", 32'd1, 32'(game_rst));
            end else if (game_rst) begin
                g_after++;
            end
        end
        check_value("pll_rst_length", 32'(PLL_PULSE), 32'(pll_hi));
        check_value("pll_rst_pulses", 32'd1, 32'(pll_rises));
        check_value("pll_rst_end", 32'd0, 32'(pll_rst));
        check_value("lock_return_game_rst", 32'd0, 32'(game_rst));
        checks++;
        assert (g_after >= HOLD && g_after <= HOLD + 2) else begin
            errors++;
            $display("game_rst stayed high %0d cycles after lock returned, outside %0d to %0d",
                     g_after, HOLD, HOLD + 2);
        end

        // Single-cycle reset requests
        pulse_request("button", 1'b0);
        pulse_request("status", 1'b1);

        // Audio reset releases on the second clk_audio edge
        repeat (2) @(posedge clk_audio);
        prev_left = '0;

        // Audio samples, mono build
        for (int s = 0; s < 12; s++) begin
            @(posedge clk_sys);
            seed = lcg_next(seed);
            exp_left = seed[31:16];
            seed = lcg_next(seed);
            right_val = seed[31:16];
            snd_left  <= exp_left;
            snd_right <= right_val;
            @(posedge clk_audio);
            @(negedge clk_audio);
            check_value("audio_l_latency", 32'(prev_left), 32'(audio_l));
            @(posedge clk_audio);
            @(negedge clk_audio);
            check_value("audio_l", 32'(exp_left), 32'(audio_l));
            check_value("audio_r_mono", 32'(exp_left), 32'(audio_r));
            prev_left = exp_left;
            repeat (2) @(posedge clk_audio);
        end

        $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: core_shell.f
common/shell_clk_pkg.sv
common/shell_av_pkg.sv
reset/pll_watchdog.sv
reset/reset_ctrl.sv
video/pixel_strobes.sv
audio/audio_resync.sv
verilog/core_shell.sv
tb/core_shell_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the shell testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module core_shell_tb \
    -f core_shell.f \
    -o core_shell_sim

./obj_dir/core_shell_sim > "$LOG" 2>&1
cat "$LOG"

if grep -qF '*** FAILED ***' "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi

if ! grep -qF '*** PASSED ***' "$LOG"; then
    echo "Simulation ended without a result, see $LOG"
    exit 1
fi

echo "Simulation passed"
